/* scroll_pkg.sv */
// scroll renderer shared constants, layer and fetch encodings, tile map geometry
package scroll_pkg;

    localparam int pxl_w = 9;                          // 5 palette bits + 4 colour bits
    localparam logic [pxl_w-1:0] blank_pxl = 9'h1ff;   // transparent / blanked pixel

    // every layer map is 64x64 entries and wraps in both directions
    localparam int map_cols = 64;
    localparam int map_rows = 64;

    // which scroll layer is being rendered, also picks the tile size
    typedef enum logic [1:0] {
        layer_idle,
        layer_1,     // 8x8 tiles
        layer_2,     // 16x16 tiles
        layer_3      // 32x32 tiles
    } layer_t;

    // per tile steps of the fetcher
    typedef enum logic [2:0] {
        f_idle,
        f_map,       // map entry read
        f_rom,       // one 32-bit row word
        f_draw,      // 8 pixels out of that word
        f_done
    } fetch_t;

    // log2 of the tile size for a layer
    function automatic logic [2:0] tile_shift(layer_t lay);
        logic [2:0] sh;
        case (lay)
            layer_1: sh = 3'd3;
            layer_2: sh = 3'd4;
            default: sh = 3'd5;
        endcase
        return sh;
    endfunction

endpackage

/* line_ram.sv */
// line buffer RAM, 1024x9 with one write port and one registered read port
`timescale 1ns/1ps

module line_ram (
    input  logic                         clk,
    input  logic [9:0]                   wr_addr,
    input  logic [scroll_pkg::pxl_w-1:0] wr_data,
    input  logic                         wr_en,
    input  logic [9:0]                   rd_addr,
    output logic [scroll_pkg::pxl_w-1:0] rd_data
);

    // two banks of 512 pixels, bank select is the top address bit
    logic [scroll_pkg::pxl_w-1:0] mem [1024];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];    // one cycle read latency
    end

endmodule

/* tile_fetch.sv */
// tile fetcher, reads map entries and tile rows and writes one layer line to the buffer
`timescale 1ns/1ps

module tile_fetch #(
    parameter int h_start = 64,
    parameter int h_end   = 448
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [8:0]                   vrender,
    input  scroll_pkg::layer_t           layer,
    input  logic [15:0]                  hpos,
    input  logic [15:0]                  vpos,
    input  logic [15:0]                  vram_base,
    input  logic                         sub_start,
    output logic                         sub_done,
    output logic [16:0]                  vram_addr,
    input  logic [15:0]                  vram_data,
    input  logic                         vram_ok,
    output logic                         vram_cs,
    output logic [21:0]                  rom_addr,
    input  logic [31:0]                  rom_data,
    input  logic                         rom_ok,
    output logic                         rom_cs,
    output logic [8:0]                   buf_addr,
    output logic [scroll_pkg::pxl_w-1:0] buf_data,
    output logic                         buf_wr
);

    localparam int col_w = $clog2(scroll_pkg::map_cols);
    localparam int row_w = $clog2(scroll_pkg::map_rows);
    localparam logic signed [10:0] win_lo = 11'(h_start);
    localparam logic signed [10:0] win_hi = 11'(h_end);

    scroll_pkg::fetch_t st;
    scroll_pkg::layer_t cur_layer;

    logic [15:0]        base_r;     // vram base held for the whole layer
    logic [row_w-1:0]   map_row;
    logic [4:0]         tile_row;   // line inside the tile
    logic [col_w-1:0]   col;
    logic signed [10:0] pos;        // buffer position of the current pixel
    logic [10:0]        code;
    logic [4:0]         pal;
    logic [31:0]        pix_word;
    logic [1:0]         word_idx;
    logic [2:0]         pix_cnt;

    logic [2:0]  sh;
    logic [2:0]  sh_in;
    logic [15:0] y_line;
    logic [15:0] mask_in;
    logic [1:0]  last_word;
    logic        in_win;

    assign sh_in   = scroll_pkg::tile_shift(layer);
    assign sh      = scroll_pkg::tile_shift(cur_layer);
    assign y_line  = 16'(vrender) + vpos;
    assign mask_in = (16'd1 << sh_in) - 16'd1;

    // words per tile row is size/8, so 1, 2 or 4
    assign last_word = 2'((3'd1 << (sh - 3'd3)) - 3'd1);

    assign vram_addr = 17'({base_r, 6'd0}) + (17'(map_row) << col_w) + 17'(col);

    // code * size * wpr + row * wpr + word
    assign rom_addr = (22'(code) << ({sh, 1'b0} - 4'd3))
                    + (22'(tile_row) << (sh - 3'd3))
                    + 22'(word_idx);

    assign vram_cs  = (st == scroll_pkg::f_map);
    assign rom_cs   = (st == scroll_pkg::f_rom);
    assign sub_done = (st == scroll_pkg::f_done);

    assign in_win   = (pos >= win_lo) && (pos < win_hi);
    assign buf_wr   = (st == scroll_pkg::f_draw) && in_win;    // edge tiles overhang the window
    assign buf_addr = pos[8:0];
    assign buf_data = {pal, pix_word[3:0]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st        <= scroll_pkg::f_idle;
            cur_layer <= scroll_pkg::layer_idle;
        end else if (sub_start) begin
            st        <= scroll_pkg::f_map;    // restarts a fetch in progress too
            cur_layer <= layer;
        end else begin
            case (st)
                scroll_pkg::f_map: begin
                    if (vram_ok) st <= scroll_pkg::f_rom;
                end
                scroll_pkg::f_rom: begin
                    if (rom_ok) st <= scroll_pkg::f_draw;
                end
                scroll_pkg::f_draw: begin
                    if (pix_cnt == 3'd7) begin
                        if (word_idx != last_word) begin
                            st <= scroll_pkg::f_rom;
                        end else if (pos + 11'sd1 >= win_hi) begin
                            st <= scroll_pkg::f_done;      // next tile starts past the window
                        end else begin
                            st <= scroll_pkg::f_map;
                        end
                    end
                end
                default: st <= scroll_pkg::f_idle;
            endcase
        end
    end

    // tile position and pixel data
    always_ff @(posedge clk) begin
        if (sub_start) begin
            base_r   <= vram_base;
            map_row  <= row_w'(y_line >> sh_in);
            tile_row <= 5'(y_line & mask_in);
            col      <= col_w'(hpos >> sh_in);
            pos      <= win_lo - 11'(hpos & mask_in);   // first tile may start left of the window
            word_idx <= 2'd0;
            pix_cnt  <= 3'd0;
        end else begin
            case (st)
                scroll_pkg::f_map: begin
                    if (vram_ok) begin
                        code <= vram_data[10:0];
                        pal  <= vram_data[15:11];
                    end
                end
                scroll_pkg::f_rom: begin
                    if (rom_ok) pix_word <= rom_data;
                end
                scroll_pkg::f_draw: begin
                    pos      <= pos + 11'sd1;
                    pix_cnt  <= pix_cnt + 3'd1;
                    pix_word <= pix_word >> 4;     // pixel 0 sits in the low nibble
                    if (pix_cnt == 3'd7) begin
                        if (word_idx != last_word) begin
                            word_idx <= word_idx + 2'd1;
                        end else begin
                            word_idx <= 2'd0;
                            col      <= col + 1'b1;    // wraps at the map edge
                        end
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

/* layer_seq.sv */
// layer sequencer, steps through the three scroll layers once per line
`timescale 1ns/1ps

module layer_seq (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic [3:0]         gfx_en,     // bit 3 is for the sprite path
    input  logic [15:0]        vram1_base,
    input  logic [15:0]        vram2_base,
    input  logic [15:0]        vram3_base,
    input  logic [15:0]        hpos1,
    input  logic [15:0]        hpos2,
    input  logic [15:0]        hpos3,
    input  logic [15:0]        vpos1,
    input  logic [15:0]        vpos2,
    input  logic [15:0]        vpos3,
    input  logic               sub_done,
    output scroll_pkg::layer_t layer,
    output logic [15:0]        hpos,
    output logic [15:0]        vpos,
    output logic [15:0]        vram_base,
    output logic               sub_start,
    output logic               line_done
);

    scroll_pkg::layer_t next_layer;
    logic skip;       // current layer disabled, nothing to wait for
    logic advance;
    logic en_next;

    // a stale sub_done while a new fetch is being issued is ignored
    assign advance = (layer != scroll_pkg::layer_idle) && ((sub_done && !sub_start) || skip);

    always_comb begin
        next_layer = layer;
        if (start) begin
            next_layer = scroll_pkg::layer_1;
        end else if (advance) begin
            case (layer)
                scroll_pkg::layer_1: next_layer = scroll_pkg::layer_2;
                scroll_pkg::layer_2: next_layer = scroll_pkg::layer_3;
                default:             next_layer = scroll_pkg::layer_idle;
            endcase
        end
    end

    always_comb begin
        case (next_layer)
            scroll_pkg::layer_1: en_next = gfx_en[0];
            scroll_pkg::layer_2: en_next = gfx_en[1];
            scroll_pkg::layer_3: en_next = gfx_en[2];
            default:             en_next = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            layer     <= scroll_pkg::layer_idle;
            sub_start <= 1'b0;
            line_done <= 1'b0;
            skip      <= 1'b0;
        end else begin
            sub_start <= 1'b0;
            line_done <= 1'b0;
            if (start || advance) begin
                layer     <= next_layer;
                sub_start <= en_next;
                skip      <= (next_layer != scroll_pkg::layer_idle) && !en_next;
                line_done <= (next_layer == scroll_pkg::layer_idle);  // after layer 3
            end
        end
    end

    // scroll registers of the layer about to be fetched
    always_ff @(posedge clk) begin
        if (start || advance) begin
            case (next_layer)
                scroll_pkg::layer_1: begin
                    hpos      <= hpos1;
                    vpos      <= vpos1;
                    vram_base <= vram1_base;
                end
                scroll_pkg::layer_2: begin
                    hpos      <= hpos2;
                    vpos      <= vpos2;
                    vram_base <= vram2_base;
                end
                scroll_pkg::layer_3: begin
                    hpos      <= hpos3;
                    vpos      <= vpos3;
                    vram_base <= vram3_base;
                end
                default: ;
            endcase
        end
    end

endmodule

/* line_out.sv */
// output side, double banked line buffers per layer with window blanking and layer masking
`timescale 1ns/1ps

module line_out #(
    parameter int h_start = 64,
    parameter int h_end   = 448
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [8:0]                   hdump,
    input  logic [8:0]                   vdump,
    input  scroll_pkg::layer_t           layer,
    input  logic [8:0]                   buf_addr,
    input  logic [scroll_pkg::pxl_w-1:0] buf_data,
    input  logic                         buf_wr,
    input  logic [3:0]                   gfx_en,     // bit 3 is for the sprite path
    output logic [scroll_pkg::pxl_w-1:0] scr1_pxl,
    output logic [scroll_pkg::pxl_w-1:0] scr2_pxl,
    output logic [scroll_pkg::pxl_w-1:0] scr3_pxl
);

    localparam logic [9:0] win_lo = 10'(h_start);
    localparam logic [9:0] win_hi = 10'(h_end);

    logic [9:0] wr_addr;
    logic [9:0] rd_addr;
    logic [2:0] wr_en;
    logic [8:0] hdump_d;    // lines up with the RAM read data
    logic       in_win;
    logic [scroll_pkg::pxl_w-1:0] rd_pxl [3];

    assign wr_addr = {vdump[0], buf_addr};     // render bank
    assign rd_addr = {~vdump[0], hdump};       // bank filled during the previous line

    assign wr_en[0] = buf_wr && (layer == scroll_pkg::layer_1);
    assign wr_en[1] = buf_wr && (layer == scroll_pkg::layer_2);
    assign wr_en[2] = buf_wr && (layer == scroll_pkg::layer_3);

    for (genvar i = 0; i < 3; i++) begin : g_line
        line_ram line_ram_inst (
            .clk     (clk),
            .wr_addr (wr_addr),
            .wr_data (buf_data),
            .wr_en   (wr_en[i]),
            .rd_addr (rd_addr),
            .rd_data (rd_pxl[i])
        );
    end

    assign in_win = ({1'b0, hdump_d} >= win_lo) && ({1'b0, hdump_d} < win_hi);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump_d  <= 9'd0;
            scr1_pxl <= scroll_pkg::blank_pxl;
            scr2_pxl <= scroll_pkg::blank_pxl;
            scr3_pxl <= scroll_pkg::blank_pxl;
        end else begin
            hdump_d  <= hdump;
            scr1_pxl <= (in_win && gfx_en[0]) ? rd_pxl[0] : scroll_pkg::blank_pxl;
            scr2_pxl <= (in_win && gfx_en[1]) ? rd_pxl[1] : scroll_pkg::blank_pxl;
            scr3_pxl <= (in_win && gfx_en[2]) ? rd_pxl[2] : scroll_pkg::blank_pxl;
        end
    end

endmodule

/* scroll_top.sv */
// scroll layer renderer top, sequencer plus tile fetcher plus line output
`timescale 1ns/1ps

module scroll_top #(
    parameter int h_start = 64,
    parameter int h_end   = 448
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [8:0]                   hdump,
    input  logic [8:0]                   vdump,
    input  logic [8:0]                   vrender,    // line after vdump
    input  logic [15:0]                  vram1_base,
    input  logic [15:0]                  vram2_base,
    input  logic [15:0]                  vram3_base,
    input  logic [15:0]                  hpos1,
    input  logic [15:0]                  hpos2,
    input  logic [15:0]                  hpos3,
    input  logic [15:0]                  vpos1,
    input  logic [15:0]                  vpos2,
    input  logic [15:0]                  vpos3,
    input  logic                         start,
    input  logic [3:0]                   gfx_en,
    output logic                         line_done,
    output logic [16:0]                  vram_addr,
    input  logic [15:0]                  vram_data,
    input  logic                         vram_ok,
    output logic                         vram_cs,
    output logic [21:0]                  rom_addr,
    input  logic [31:0]                  rom_data,
    input  logic                         rom_ok,
    output logic                         rom_cs,
    output logic [scroll_pkg::pxl_w-1:0] scr1_pxl,
    output logic [scroll_pkg::pxl_w-1:0] scr2_pxl,
    output logic [scroll_pkg::pxl_w-1:0] scr3_pxl
);

    scroll_pkg::layer_t layer;
    logic [15:0] hpos;
    logic [15:0] vpos;
    logic [15:0] vram_base;
    logic        sub_start;
    logic        sub_done;
    logic [8:0]  buf_addr;
    logic [scroll_pkg::pxl_w-1:0] buf_data;
    logic        buf_wr;

    layer_seq layer_seq_inst (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .gfx_en     (gfx_en),
        .vram1_base (vram1_base),
        .vram2_base (vram2_base),
        .vram3_base (vram3_base),
        .hpos1      (hpos1),
        .hpos2      (hpos2),
        .hpos3      (hpos3),
        .vpos1      (vpos1),
        .vpos2      (vpos2),
        .vpos3      (vpos3),
        .sub_done   (sub_done),
        .layer      (layer),
        .hpos       (hpos),
        .vpos       (vpos),
        .vram_base  (vram_base),
        .sub_start  (sub_start),
        .line_done  (line_done)
    );

    tile_fetch #(
        .h_start (h_start),
        .h_end   (h_end)
    ) tile_fetch_inst (
        .clk       (clk),
        .rst       (rst),
        .vrender   (vrender),
        .layer     (layer),
        .hpos      (hpos),
        .vpos      (vpos),
        .vram_base (vram_base),
        .sub_start (sub_start),
        .sub_done  (sub_done),
        .vram_addr (vram_addr),
        .vram_data (vram_data),
        .vram_ok   (vram_ok),
        .vram_cs   (vram_cs),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .rom_cs    (rom_cs),
        .buf_addr  (buf_addr),
        .buf_data  (buf_data),
        .buf_wr    (buf_wr)
    );

    line_out #(
        .h_start (h_start),
        .h_end   (h_end)
    ) line_out_inst (
        .clk      (clk),
        .rst      (rst),
        .hdump    (hdump),
        .vdump    (vdump),
        .layer    (layer),
        .buf_addr (buf_addr),
        .buf_data (buf_data),
        .buf_wr   (buf_wr),
        .gfx_en   (gfx_en),
        .scr1_pxl (scr1_pxl),
        .scr2_pxl (scr2_pxl),
        .scr3_pxl (scr3_pxl)
    );

endmodule

/* scroll_tb_mem.sv */
// testbench video RAM and tile ROM models, random contents and random response latency
`timescale 1ns/1ps

module scroll_tb_mem #(
    parameter logic [31:0] seed = 32'h20fe807e
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [16:0] vram_addr,
    input  logic        vram_cs,
    output logic [15:0] vram_data,
    output logic        vram_ok,
    input  logic [21:0] rom_addr,
    input  logic        rom_cs,
    output logic [31:0] rom_data,
    output logic        rom_ok
);

    logic [15:0] vram_mem [131072];
    logic [31:0] rom_mem [262144];     // largest code of layer 3 stays below 2^18 words
    logic [31:0] lat_state;
    logic        vram_pend;
    logic        rom_pend;
    logic [1:0]  vram_wait;
    logic [1:0]  rom_wait;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin : fill
        logic [31:0] s;
        s = seed;
        for (int i = 0; i < 131072; i++) begin
            s = lcg_next(s);
            vram_mem[i] = s[31:16];
        end
        for (int i = 0; i < 262144; i++) begin
            s = lcg_next(s);
            rom_mem[i] = s;
        end
    end

    // each request waits 1 to 4 cycles before ok
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lat_state <= seed;
            vram_pend <= 1'b0;
            rom_pend  <= 1'b0;
            vram_wait <= 2'd0;
            rom_wait  <= 2'd0;
            vram_ok   <= 1'b0;
            rom_ok    <= 1'b0;
            vram_data <= 16'd0;
            rom_data  <= 32'd0;
        end else begin
            lat_state <= lcg_next(lat_state);
            vram_ok   <= 1'b0;
            rom_ok    <= 1'b0;
            if (vram_cs && !vram_ok) begin
                if (!vram_pend) begin
                    vram_pend <= 1'b1;
                    vram_wait <= lat_state[17:16];
                end else if (vram_wait == 2'd0) begin
                    vram_pend <= 1'b0;
                    vram_ok   <= 1'b1;
                    vram_data <= vram_mem[vram_addr];
                end else begin
                    vram_wait <= vram_wait - 2'd1;
                end
            end
            if (rom_cs && !rom_ok) begin
                if (!rom_pend) begin
                    rom_pend <= 1'b1;
                    rom_wait <= lat_state[25:24];
                end else if (rom_wait == 2'd0) begin
                    rom_pend <= 1'b0;
                    rom_ok   <= 1'b1;
                    rom_data <= rom_mem[rom_addr[17:0]];
                end else begin
                    rom_wait <= rom_wait - 2'd1;
                end
            end
        end
    end

endmodule

/* scroll_assert.sv */
// fetcher protocol checks, strobes held until ok, single cycle done, writes inside the window
`timescale 1ns/1ps

module scroll_assert #(
    parameter int h_start = 64,
    parameter int h_end   = 448
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sub_start,
    input  logic                 sub_done,
    input  logic                 vram_cs,
    input  logic                 vram_ok,
    input  logic [16:0]          vram_addr,
    input  logic                 rom_cs,
    input  logic                 rom_ok,
    input  logic [21:0]          rom_addr,
    input  logic                 buf_wr,
    input  logic [8:0]           buf_addr
);

    localparam logic [9:0] win_lo = 10'(h_start);
    localparam logic [9:0] win_hi = 10'(h_end);

    vram_hold: assert property (@(posedge clk) disable iff (rst)
        vram_cs && !vram_ok && !sub_start |=> vram_cs && $stable(vram_addr))
        else $error("vram request dropped or address moved before ok");

    rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok && !sub_start |=> rom_cs && $stable(rom_addr))
        else $error("rom request dropped or address moved before ok");

    done_pulse: assert property (@(posedge clk) disable iff (rst)
        sub_done |=> !sub_done)
        else $error("sub_done longer than one cycle");

    wr_window: assert property (@(posedge clk) disable iff (rst)
        buf_wr |-> ({1'b0, buf_addr} >= win_lo) && ({1'b0, buf_addr} < win_hi))
        else $error("line buffer write outside the active window");

endmodule

bind tile_fetch scroll_assert #(
    .h_start (h_start),
    .h_end   (h_end)
) scroll_assert_inst (
    .clk       (clk),
    .rst       (rst),
    .sub_start (sub_start),
    .sub_done  (sub_done),
    .vram_cs   (vram_cs),
    .vram_ok   (vram_ok),
    .vram_addr (vram_addr),
    .rom_cs    (rom_cs),
    .rom_ok    (rom_ok),
    .rom_addr  (rom_addr),
    .buf_wr    (buf_wr),
    .buf_addr  (buf_addr)
);

/* scroll_tb.sv */
// scroll renderer testbench, renders lines and checks the readout against a reference model
`timescale 1ns/1ps

module scroll_tb;

    localparam int h_start   = 64;
    localparam int h_end     = 448;
    localparam int num_lines = 25;
    localparam int fetch_max = 3000;                       // worst case render of one line
    localparam int cycle_max = 40 * (512 + fetch_max);

    logic        clk = 1'b0;
    logic        rst;
    logic [8:0]  hdump;
    logic [8:0]  vdump;
    logic [8:0]  vrender;
    logic        start;
    logic [3:0]  gfx_en;
    logic        line_done;
    logic [15:0] hpos_in [3];
    logic [15:0] vpos_in [3];
    logic [15:0] base_in [3];
    logic [8:0]  scr_pxl [3];
    logic [16:0] vram_addr;
    logic [15:0] vram_data;
    logic        vram_ok;
    logic        vram_cs;
    logic [21:0] rom_addr;
    logic [31:0] rom_data;
    logic        rom_ok;
    logic        rom_cs;

    // scroll registers of the line being read out
    logic [15:0] shown_hpos [3];
    logic [15:0] shown_vpos [3];
    logic [15:0] shown_base [3];
    logic [8:0]  shown_line;
    logic [31:0] lcg_state;
    logic        chk_en = 1'b0;
    logic        en_d1 = 1'b0;
    logic        en_d2 = 1'b0;
    logic [8:0]  h_d1;
    logic [8:0]  h_d2;
    int          cycles = 0;
    int          done_cnt;
    int          starts = 0;

    scroll_top #(
        .h_start (h_start),
        .h_end   (h_end)
    ) scroll_top_inst (
        .clk        (clk),
        .rst        (rst),
        .hdump      (hdump),
        .vdump      (vdump),
        .vrender    (vrender),
        .vram1_base (base_in[0]),
        .vram2_base (base_in[1]),
        .vram3_base (base_in[2]),
        .hpos1      (hpos_in[0]),
        .hpos2      (hpos_in[1]),
        .hpos3      (hpos_in[2]),
        .vpos1      (vpos_in[0]),
        .vpos2      (vpos_in[1]),
        .vpos3      (vpos_in[2]),
        .start      (start),
        .gfx_en     (gfx_en),
        .line_done  (line_done),
        .vram_addr  (vram_addr),
        .vram_data  (vram_data),
        .vram_ok    (vram_ok),
        .vram_cs    (vram_cs),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .rom_cs     (rom_cs),
        .scr1_pxl   (scr_pxl[0]),
        .scr2_pxl   (scr_pxl[1]),
        .scr3_pxl   (scr_pxl[2])
    );

    scroll_tb_mem scroll_tb_mem_inst (
        .clk       (clk),
        .rst       (rst),
        .vram_addr (vram_addr),
        .vram_cs   (vram_cs),
        .vram_data (vram_data),
        .vram_ok   (vram_ok),
        .rom_addr  (rom_addr),
        .rom_cs    (rom_cs),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected pixel of layer lay at screen position h
    function automatic logic [8:0] ref_pixel(input int lay, input int h, input logic [15:0] hp,
                                             input logic [15:0] vp, input logic [15:0] base,
                                             input logic [8:0] line, input logic en);
        int          sh;
        int          size;
        int          mx;
        int          px;
        int          tile_row;
        int          map_row;
        logic [15:0] y;
        logic [16:0] vaddr;
        logic [15:0] entry;
        logic [31:0] raddr;
        logic [31:0] word;
        if (h < h_start || h >= h_end || !en) begin
            return scroll_pkg::blank_pxl;
        end
        sh       = 3 + lay;
        size     = 1 << sh;
        y        = {7'd0, line} + vp;
        map_row  = int'(y >> sh) % scroll_pkg::map_rows;
        tile_row = int'(y) % size;
        mx       = (h - h_start + int'(hp)) % (scroll_pkg::map_cols * size);   // map wrap
        px       = mx % size;
        vaddr    = 17'(int'(base) * 64 + map_row * 64 + mx / size);
        entry    = scroll_tb_mem_inst.vram_mem[vaddr];
        raddr    = int'(entry[10:0]) * size * (size / 8) + tile_row * (size / 8) + px / 8;
        word     = scroll_tb_mem_inst.rom_mem[raddr[17:0]];
        return {entry[15:11], 4'(word >> (4 * (px % 8)))};
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        if (got !== want) begin
            $display("Fail at %0t ns: %s, got %h expected %h", $time, what, got, want);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic pick_scroll(input logic random);
        for (int k = 0; k < 3; k++) begin
            lcg_state  = lcg_next(lcg_state);
            hpos_in[k] = random ? lcg_state[31:16] : 16'd0;
            lcg_state  = lcg_next(lcg_state);
            vpos_in[k] = random ? lcg_state[31:16] : 16'd0;
            lcg_state  = lcg_next(lcg_state);
            base_in[k] = random ? lcg_state[31:16] : 16'(k * 256);
        end
    endtask

    task automatic pulse_start;
        start  = 1'b1;
        starts = starts + 1;
        next_cycle;
        start  = 1'b0;
    endtask

    task automatic wait_line_done;
        int waited;
        waited = 0;
        while (done_cnt < starts && waited < fetch_max) begin
            next_cycle;
            waited++;
        end
        if (done_cnt < starts) begin
            $display("line_done never came for render %0d after %0d cycles", starts, waited);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic sweep_line;
        chk_en = 1'b1;
        for (int h = 0; h < 512; h++) begin
            hdump = 9'(h);
            next_cycle;
        end
        chk_en = 1'b0;
        repeat (3) next_cycle;     // drain the compare pipeline
    endtask

    // cleared enable bits stay cleared, a skipped layer leaves a stale bank
    function automatic logic [3:0] enable_for(input int line);
        if (line >= 23) return 4'b1001;
        else if (line >= 21) return 4'b1101;
        else return 4'b1111;
    endfunction

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_max) begin
            $display("simulation ran past the limit of %0d cycles", cycle_max);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) done_cnt <= 0;
        else if (line_done) done_cnt <= done_cnt + 1;
    end

    // scr for hdump h is due two cycles later
    always @(negedge clk) begin : compare
        logic [8:0] want;
        if (en_d2) begin
            for (int k = 0; k < 3; k++) begin
                want = ref_pixel(k, int'(h_d2), shown_hpos[k], shown_vpos[k],
                                 shown_base[k], shown_line, gfx_en[k]);
                check_value(32'(scr_pxl[k]), 32'(want),
                            $sformatf("layer %0d line %0d x %0d", k + 1, shown_line, h_d2));
            end
        end
        h_d1  <= hdump;
        h_d2  <= h_d1;
        en_d1 <= chk_en;
        en_d2 <= en_d1;
    end

    initial begin
        rst       = 1'b1;
        hdump     = 9'd0;
        vdump     = 9'd0;
        vrender   = 9'd0;
        start     = 1'b0;
        gfx_en    = 4'b1111;
        lcg_state = 32'h20fe807e;
        pick_scroll(1'b0);
        repeat (16) @(posedge clk);
        #1;
        // reset values of the output registers
        for (int k = 0; k < 3; k++) begin
            check_value(32'(scr_pxl[k]), 32'(scroll_pkg::blank_pxl), "scr output in reset");
        end
        rst = 1'b0;
        next_cycle;
        next_cycle;
        check_value(32'(vram_cs), 32'd0, "vram_cs after reset");
        check_value(32'(rom_cs), 32'd0, "rom_cs after reset");
        check_value(32'(line_done), 32'd0, "line_done after reset");

        // line 0 with zero scroll renders on its own
        vdump   = 9'h1ff;
        vrender = 9'd0;
        pulse_start;
        wait_line_done;
        for (int line = 0; line < num_lines; line++) begin
            shown_hpos = hpos_in;
            shown_vpos = vpos_in;
            shown_base = base_in;
            shown_line = 9'(line);
            vdump      = 9'(line);
            if (line + 1 < num_lines) begin
                vrender = 9'(line + 1);
                gfx_en  = enable_for(line + 1);
                pick_scroll(1'b1);
                pulse_start;     // next line renders during this readout
            end
            sweep_line;
            if (line + 1 < num_lines) begin
                wait_line_done;
            end
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* compile.f */
scroll_pkg.sv
line_ram.sv
tile_fetch.sv
layer_seq.sv
line_out.sv
scroll_top.sv
scroll_tb_mem.sv
scroll_assert.sv
scroll_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module scroll_tb -f compile.f -o scroll_sim

./obj_dir/scroll_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
grep -qF "*** TEST PASSED ***" sim.log
